//--- mips_core.f
+incdir+include
hdl/isa_pkg.sv
hdl/ctrl_pkg.sv
hdl/controller.sv
hdl/fetch_unit.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/result_stage.sv
hdl/mips_core.sv
tb/mips_core_tb.sv

//--- Bender.yml
package:
  name: mips_core

sources:
  - include_dirs:
      - include
    files:
      - hdl/isa_pkg.sv
      - hdl/ctrl_pkg.sv
      - hdl/controller.sv
      - hdl/fetch_unit.sv
      - hdl/reg_file.sv
      - hdl/alu.sv
      - hdl/result_stage.sv
      - hdl/mips_core.sv
      - target: test
        files:
          - tb/mips_core_tb.sv

//--- tb/mips_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module mips_core_tb import isa_pkg::*; ();

  localparam int PROG_LEN = 32;
  localparam int DIDX = $clog2(`DMEM_WORDS);
  localparam int MAX_CYCLES = 1000;
  localparam logic [`XLEN-1:0] END_PC = `XLEN'(124); // the self-jump at word 31.

  logic             clk;
  logic             reset;
  logic             imem_we;
  logic [`XLEN-1:0] imem_addr;
  logic [`XLEN-1:0] imem_wdata;
  logic [`XLEN-1:0] pc;
  logic             dmem_we;
  logic [`XLEN-1:0] dmem_addr;
  logic [`XLEN-1:0] dmem_wdata;

  logic [`XLEN-1:0] prog [PROG_LEN];
  logic [15:0]      imm_a;
  logic [15:0]      imm_b;
  logic [15:0]      imm_c;
  int               cycles;

  // reference model state.
  logic [`XLEN-1:0] m_regs [32];
  logic [`XLEN-1:0] m_mem [`DMEM_WORDS];
  logic [`XLEN-1:0] m_pc;
  int unsigned      m_left; // stall cycles still to wait out.
  instr_t           m_ins;
  logic [`XLEN-1:0] m_a;
  logic [`XLEN-1:0] m_b;
  logic [`XLEN-1:0] m_sext;
  logic [`XLEN-1:0] m_pc4;
  logic [`XLEN-1:0] m_jump;
  logic [`XLEN-1:0] m_addr;
  logic [`XLEN-1:0] m_next;
  logic [`XLEN-1:0] m_wr_val;
  logic [4:0]       m_wr_idx;
  logic             m_wr_en;
  logic             m_we;
  logic             m_stalling;

  mips_core DUT (.clk, .reset, .imem_we, .imem_addr, .imem_wdata, .pc, .dmem_we, .dmem_addr,
    .dmem_wdata);

  always #4 clk = ~clk;

  function automatic logic [31:0] encode_r(opcode_t op, logic [4:0] rs, logic [4:0] rt,
                                           logic [4:0] rd);
    return {op, rs, rt, rd, 11'd0};
  endfunction

  function automatic logic [31:0] encode_i(opcode_t op, logic [4:0] rs, logic [4:0] rt,
                                           logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] encode_j(opcode_t op, logic [25:0] target);
    return {op, target};
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped at the first error");
  endtask

  assign m_ins      = prog[m_pc[6:2]];
  assign m_a        = m_regs[m_ins.i.rs];
  assign m_b        = m_regs[m_ins.i.rt];
  assign m_sext     = {{16{m_ins.i.imm[15]}}, m_ins.i.imm};
  assign m_pc4      = m_pc + `XLEN'(4);
  assign m_jump     = {m_pc4[31:28], m_ins.j.target, 2'b00};
  assign m_addr     = m_a + m_sext;
  assign m_we       = (m_left == 0) && (m_ins.r.op == op_sw);
  assign m_stalling = m_ins.r.op inside {op_lw, op_jal, op_bne, op_xori, op_add, op_sub, op_slt};

  always_comb begin
    m_next   = m_pc4;
    m_wr_en  = 1'b1;
    m_wr_idx = m_ins.r.rd;
    m_wr_val = '0;
    case (m_ins.r.op)
      op_lw: begin
        m_wr_idx = m_ins.i.rt;
        m_wr_val = m_mem[m_addr[DIDX+1:2]];
      end
      op_xori: begin
        m_wr_idx = m_ins.i.rt;
        m_wr_val = m_a ^ {16'h0000, m_ins.i.imm};
      end
      op_add: m_wr_val = m_a + m_b;
      op_sub: m_wr_val = m_a - m_b;
      op_slt: m_wr_val = ($signed(m_a) < $signed(m_b)) ? `XLEN'(1) : `XLEN'(0);
      op_jal: begin
        m_wr_idx = 5'(`LINK_REG);
        m_wr_val = m_pc4;
        m_next   = m_jump;
      end
      op_bne: begin
        m_wr_en = 1'b0;
        if (m_a != m_b) m_next = m_pc4 + {m_sext[29:0], 2'b00};
      end
      op_j: begin
        m_wr_en = 1'b0;
        m_next  = m_jump;
      end
      op_jr: begin
        m_wr_en = 1'b0;
        m_next  = m_a;
      end
      default: m_wr_en = 1'b0; // SW and unknown opcodes write no register.
    endcase
  end

  always @(posedge clk) begin
    if (reset) begin
      m_pc   <= '0;
      m_left <= 0;
      for (int i = 0; i < 32; i++) begin
        m_regs[i] <= '0;
      end
    end else if (m_left != 0) begin
      m_left <= m_left - 1;
    end else begin
      m_pc <= m_next;
      if (m_stalling) m_left <= `STALL_CYCLES;
      if (m_wr_en && m_wr_idx != 5'd0) m_regs[m_wr_idx] <= m_wr_val;
      if (m_we) m_mem[m_addr[DIDX+1:2]] <= m_b;
    end
  end

  // pc is compared every cycle, so the dwell after each issue is checked too.
  a_pc_matches: assert property (@(posedge clk) disable iff (reset) pc == m_pc)
    else abort_run($sformatf("CHECK FAILED at %0t: pc is %h, expected %h", $time,
      $sampled(pc), $sampled(m_pc)));

  a_store_strobe: assert property (@(posedge clk) disable iff (reset) dmem_we == m_we)
    else abort_run($sformatf("CHECK FAILED at %0t: dmem_we is %b, expected %b", $time,
      $sampled(dmem_we), $sampled(m_we)));

  a_store_value: assert property (@(posedge clk) disable iff (reset)
    m_we |-> (dmem_addr == m_addr && dmem_wdata == m_b))
    else abort_run($sformatf("CHECK FAILED at %0t: store of %h to %h, expected %h to %h",
      $time, $sampled(dmem_wdata), $sampled(dmem_addr), $sampled(m_b), $sampled(m_addr)));

  initial begin
    clk        = 1'b0;
    reset      = 1'b1;
    imem_we    = 1'b0;
    imem_addr  = '0;
    imem_wdata = '0;
    void'($urandom(32'h289760c0));
    imm_a = 16'($urandom) & 16'hfffe | 16'h0002; // even and nonzero.
    imm_b = 16'($urandom) | 16'h0001; // odd, so it always differs from imm_a.
    imm_c = 16'($urandom);
    prog[0]  = encode_i(op_xori, 5'd0, 5'd1, imm_a);
    prog[1]  = encode_i(op_xori, 5'd0, 5'd2, imm_b);
    prog[2]  = encode_r(op_add, 5'd1, 5'd2, 5'd3);
    prog[3]  = encode_r(op_sub, 5'd1, 5'd2, 5'd4);
    prog[4]  = encode_r(op_sub, 5'd0, 5'd1, 5'd5); // a negative operand for SLT.
    prog[5]  = encode_r(op_slt, 5'd5, 5'd2, 5'd6);
    prog[6]  = encode_r(op_slt, 5'd2, 5'd5, 5'd7);
    prog[7]  = encode_r(op_slt, 5'd4, 5'd5, 5'd8);
    for (int i = 0; i < 8; i++) begin
      prog[8+i] = encode_i(op_sw, 5'd0, 5'(i + 1), 16'(i * 4));
    end
    prog[16] = encode_i(op_lw, 5'd0, 5'd9, 16'd8);
    prog[17] = encode_i(op_sw, 5'd0, 5'd9, 16'd64);
    prog[18] = encode_r(op_add, 5'd1, 5'd2, 5'd0);
    prog[19] = encode_i(op_sw, 5'd0, 5'd0, 16'd32);
    prog[20] = 32'hfc00_0000; // opcode outside the subset.
    prog[21] = encode_i(op_bne, 5'd1, 5'd1, 16'd5);
    prog[22] = encode_i(op_bne, 5'd1, 5'd2, 16'd1);
    prog[23] = encode_i(op_xori, 5'd0, 5'd10, 16'hdead);
    prog[24] = encode_j(op_jal, 26'd27);
    prog[25] = encode_i(op_sw, 5'd0, 5'd31, 16'd36);
    prog[26] = encode_j(op_j, 26'd30);
    prog[27] = encode_i(op_xori, 5'd0, 5'd12, imm_c);
    prog[28] = encode_i(op_sw, 5'd0, 5'd12, 16'd40);
    prog[29] = encode_r(op_jr, 5'd31, 5'd0, 5'd0);
    prog[30] = encode_i(op_sw, 5'd0, 5'd10, 16'd44);
    prog[31] = encode_j(op_j, 26'd31);

    // the program goes in under reset, then reset stays up for 5 more cycles.
    @(negedge clk);
    for (int i = 0; i < PROG_LEN; i++) begin
      imem_we    = 1'b1;
      imem_addr  = `XLEN'(i * 4);
      imem_wdata = prog[i];
      @(negedge clk);
    end
    imem_we = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;

    cycles = 0;
    while (pc !== END_PC && cycles < MAX_CYCLES) begin
      @(negedge clk);
      cycles++;
    end
    if (pc !== END_PC) begin
      abort_run("program did not reach its end address");
    end else begin
      repeat (4) @(negedge clk);
      $display("PASS: all tests");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- hdl/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module mips_core import isa_pkg::*, ctrl_pkg::*; (
  input  logic             clk,
  input  logic             reset,
  input  logic             imem_we,
  input  logic [`XLEN-1:0] imem_addr,
  input  logic [`XLEN-1:0] imem_wdata,
  output logic [`XLEN-1:0] pc,
  output logic             dmem_we,
  output logic [`XLEN-1:0] dmem_addr,
  output logic [`XLEN-1:0] dmem_wdata
);

  instr_t                 instr;
  alu_op_t                alu_op;
  logic                   reg_write;
  logic                   mem_to_reg;
  logic                   mem_write;
  logic                   branch;
  logic                   alu_src;
  logic                   reg_dst;
  logic                   pc_write;
  logic                   pc_jump;
  logic                   pc_reg;
  logic                   link;
  logic                   zero;
  logic [`XLEN-1:0]       pc_plus4;
  logic [`XLEN-1:0]       rs_data;
  logic [`XLEN-1:0]       rt_data;
  logic [`XLEN-1:0]       imm_ext;
  logic [`XLEN-1:0]       alu_b;
  logic [`XLEN-1:0]       alu_y;
  logic [`XLEN-1:0]       wb_data;
  logic [`REG_ADDR_W-1:0] wa;

  controller u_controller (.clk, .reset, .op(instr.r.op), .reg_write, .mem_to_reg,
    .mem_write, .branch, .alu_src, .reg_dst, .pc_write, .pc_jump, .pc_reg, .link, .alu_op);

  fetch_unit u_fetch (.clk, .reset, .imem_we, .pc_write, .pc_jump, .pc_reg, .branch, .zero,
    .imem_addr, .imem_wdata, .rs_data, .pc, .pc_plus4, .instr);

  // XORI is a logical immediate and takes zero extension.
  assign imm_ext = (instr.i.op == op_xori) ? {{(`XLEN-16){1'b0}}, instr.i.imm}
                                           : {{(`XLEN-16){instr.i.imm[15]}}, instr.i.imm};
  assign alu_b   = alu_src ? imm_ext : rt_data;

  assign wa = link    ? `REG_ADDR_W'(`LINK_REG) :
              reg_dst ? instr.r.rd : instr.i.rt;

  reg_file u_reg_file (.clk, .reset, .we(reg_write), .ra1(instr.i.rs), .ra2(instr.i.rt),
    .wa, .wd(wb_data), .rd1(rs_data), .rd2(rt_data));

  alu u_alu (.a(rs_data), .b(alu_b), .op(alu_op), .y(alu_y), .zero);

  result_stage u_result (.clk, .mem_write, .mem_to_reg, .link, .alu_y,
    .store_data(rt_data), .pc_plus4, .wb_data);

  assign dmem_we    = mem_write;
  assign dmem_addr  = alu_y;
  assign dmem_wdata = rt_data;

endmodule

`default_nettype wire

//--- hdl/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module result_stage (
  input  logic             clk,
  input  logic             mem_write,
  input  logic             mem_to_reg,
  input  logic             link,
  input  logic [`XLEN-1:0] alu_y,
  input  logic [`XLEN-1:0] store_data,
  input  logic [`XLEN-1:0] pc_plus4,
  output logic [`XLEN-1:0] wb_data
);

  localparam int IDX_W = $clog2(`DMEM_WORDS);

  logic [`XLEN-1:0] dmem [`DMEM_WORDS];
  logic [`XLEN-1:0] load_data;

  // the alu result is the byte address, the low two bits are ignored.
  assign load_data = dmem[alu_y[IDX_W+1:2]];

  always_ff @(posedge clk) begin
    if (mem_write) dmem[alu_y[IDX_W+1:2]] <= store_data;
  end

  always_comb begin
    if (link)
      wb_data = pc_plus4; // return address for JAL.
    else if (mem_to_reg)
      wb_data = load_data;
    else
      wb_data = alu_y;
  end

  a_store_in_range: assert property (@(posedge clk)
    mem_write |-> alu_y < `XLEN'(`DMEM_WORDS * 4));

endmodule

`default_nettype wire

//--- hdl/alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module alu import ctrl_pkg::*; (
  input  logic [`XLEN-1:0] a,
  input  logic [`XLEN-1:0] b,
  input  alu_op_t          op,
  output logic [`XLEN-1:0] y,
  output logic             zero
);

  logic less;

  assign less = $signed(a) < $signed(b);

  always_comb begin
    case (op)
      alu_add: y = a + b;
      alu_sub: y = a - b;
      alu_xor: y = a ^ b;
      alu_slt: y = {{(`XLEN-1){1'b0}}, less};
      default: y = '0;
    endcase
  end

  assign zero = (y == '0); // BNE branches when this is low.

endmodule

`default_nettype wire

//--- hdl/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module reg_file (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   we,
  input  logic [`REG_ADDR_W-1:0] ra1,
  input  logic [`REG_ADDR_W-1:0] ra2,
  input  logic [`REG_ADDR_W-1:0] wa,
  input  logic [`XLEN-1:0]       wd,
  output logic [`XLEN-1:0]       rd1,
  output logic [`XLEN-1:0]       rd2
);

  localparam int NREGS = 2 ** `REG_ADDR_W;

  logic [`XLEN-1:0] regs [NREGS];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && wa != '0) begin
      regs[wa] <= wd; // writes to $0 are dropped.
    end
  end

  // reads see the value from before this cycle's write.
  assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
  assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

`default_nettype wire

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module fetch_unit import isa_pkg::*; (
  input  logic              clk,
  input  logic              reset,
  input  logic              imem_we,
  input  logic              pc_write,
  input  logic              pc_jump,
  input  logic              pc_reg,
  input  logic              branch,
  input  logic              zero,
  input  logic [`XLEN-1:0]  imem_addr,
  input  logic [`XLEN-1:0]  imem_wdata,
  input  logic [`XLEN-1:0]  rs_data,
  output logic [`XLEN-1:0]  pc,
  output logic [`XLEN-1:0]  pc_plus4,
  output instr_t            instr
);

  localparam int IDX_W = $clog2(`IMEM_WORDS);

  logic [`XLEN-1:0] imem [`IMEM_WORDS];
  logic [`XLEN-1:0] pc_next;
  logic [`XLEN-1:0] br_offset;
  logic [`XLEN-1:0] jump_target;

  assign pc_plus4 = pc + `XLEN'(4);
  assign instr    = imem[pc[IDX_W+1:2]];

  assign br_offset   = {{(`XLEN-18){instr.i.imm[15]}}, instr.i.imm, 2'b00};
  assign jump_target = {pc_plus4[`XLEN-1:`XLEN-4], instr.j.target, 2'b00};

  always_comb begin
    if (pc_reg)
      pc_next = rs_data;
    else if (pc_jump)
      pc_next = jump_target;
    else if (branch && !zero)
      pc_next = pc_plus4 + br_offset; // BNE taken.
    else
      pc_next = pc_plus4;
  end

  // imem_addr is a byte address, the same as the pc.
  always_ff @(posedge clk) begin
    if (imem_we) imem[imem_addr[IDX_W+1:2]] <= imem_wdata;
  end

  always_ff @(posedge clk) begin
    if (reset) pc <= '0;
    else if (pc_write) pc <= pc_next;
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00);

  a_one_jump_src: assert property (@(posedge clk) disable iff (reset)
    !(pc_jump && pc_reg));

endmodule

`default_nettype wire

//--- hdl/controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module controller import isa_pkg::*, ctrl_pkg::*; (
  input  logic    clk,
  input  logic    reset,
  input  opcode_t op,
  output logic    reg_write,
  output logic    mem_to_reg,
  output logic    mem_write,
  output logic    branch,
  output logic    alu_src,
  output logic    reg_dst,
  output logic    pc_write,
  output logic    pc_jump,
  output logic    pc_reg,
  output logic    link,
  output alu_op_t alu_op
);

  localparam int CNT_W = $clog2(`STALL_CYCLES + 1);

  ctrl_state_t      state;
  logic [CNT_W-1:0] stall_cnt;
  logic             stall_start;

  always_comb begin
    reg_write   = 1'b0;
    mem_to_reg  = 1'b0;
    mem_write   = 1'b0;
    branch      = 1'b0;
    alu_src     = 1'b0;
    reg_dst     = 1'b0;
    pc_write    = 1'b0;
    pc_jump     = 1'b0;
    pc_reg      = 1'b0;
    link        = 1'b0;
    alu_op      = alu_add;
    stall_start = 1'b0;
    if (state == st_issue) begin
      pc_write = 1'b1; // unknown opcodes also move the pc.
      case (op)
        op_lw: begin
          reg_write   = 1'b1;
          mem_to_reg  = 1'b1;
          alu_src     = 1'b1;
          stall_start = 1'b1;
        end
        op_sw: begin
          mem_write = 1'b1;
          alu_src   = 1'b1;
        end
        op_j: pc_jump = 1'b1;
        op_jr: pc_reg = 1'b1;
        op_jal: begin
          reg_write   = 1'b1;
          pc_jump     = 1'b1;
          link        = 1'b1;
          stall_start = 1'b1;
        end
        op_bne: begin
          branch      = 1'b1;
          alu_op      = alu_sub; // zero flag compares rs with rt.
          stall_start = 1'b1;
        end
        op_xori: begin
          reg_write   = 1'b1;
          alu_src     = 1'b1;
          alu_op      = alu_xor;
          stall_start = 1'b1;
        end
        op_add: begin
          reg_write   = 1'b1;
          reg_dst     = 1'b1;
          stall_start = 1'b1;
        end
        op_sub: begin
          reg_write   = 1'b1;
          reg_dst     = 1'b1;
          alu_op      = alu_sub;
          stall_start = 1'b1;
        end
        op_slt: begin
          reg_write   = 1'b1;
          reg_dst     = 1'b1;
          alu_op      = alu_slt;
          stall_start = 1'b1;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= st_issue;
      stall_cnt <= '0;
    end else begin
      case (state)
        st_issue: if (stall_start) state <= st_stall;
        st_stall: begin
          if (stall_cnt == CNT_W'(`STALL_CYCLES - 1)) begin
            state     <= st_issue;
            stall_cnt <= '0;
          end else begin
            stall_cnt <= stall_cnt + 1'b1;
          end
        end
        default: state <= st_issue;
      endcase
    end
  end

  // nothing may change architectural state while the gap is being waited out.
  a_stall_quiet: assert property (@(posedge clk) disable iff (reset)
    stall_start |=> (!(pc_write || reg_write || mem_write)) [*`STALL_CYCLES] ##1 pc_write);

  a_stall_bound: assert property (@(posedge clk) disable iff (reset)
    stall_cnt < CNT_W'(`STALL_CYCLES));

endmodule

`default_nettype wire

//--- hdl/ctrl_pkg.sv
`default_nettype none

package ctrl_pkg;

  typedef enum logic [1:0] {
    alu_add = 2'b00,
    alu_sub = 2'b01,
    alu_xor = 2'b10,
    alu_slt = 2'b11
  } alu_op_t;

  // the controller either issues an instruction or waits out the hazard gap.
  typedef enum logic {
    st_issue = 1'b0,
    st_stall = 1'b1
  } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // only the opcode field is decoded, so ADD, SUB and SLT have their own opcodes.
  typedef enum logic [5:0] {
    op_lw   = 6'b100011,
    op_sw   = 6'b101011,
    op_j    = 6'b000010,
    op_jr   = 6'b001000,
    op_jal  = 6'b000011,
    op_bne  = 6'b000101,
    op_xori = 6'b001110,
    op_add  = 6'b100000,
    op_sub  = 6'b100010,
    op_slt  = 6'b101010
  } opcode_t;

  typedef struct packed {
    opcode_t    op;
    logic [4:0] rs;
    logic [4:0] rt;
    logic [4:0] rd;
    logic [4:0] shamt;
    logic [5:0] funct;
  } r_fmt_t;

  typedef struct packed {
    opcode_t     op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [15:0] imm;
  } i_fmt_t;

  typedef struct packed {
    opcode_t     op;
    logic [25:0] target;
  } j_fmt_t;

  // one instruction word seen through each of the three encodings.
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    j_fmt_t j;
  } instr_t;

endpackage

`default_nettype wire

//--- include/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// data path and address width.
`define XLEN 32

// register index width, which gives 32 architectural registers.
`define REG_ADDR_W 5

// memory depths in 32-bit words.
`define IMEM_WORDS 256
`define DMEM_WORDS 256

// idle cycles that follow an instruction which writes a register or resolves a branch.
`define STALL_CYCLES 3

// register written by JAL.
`define LINK_REG 31

`endif
